/* Makefile */
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: no pass line in log"; exit 1; fi
	@echo "Result: passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sources.f */
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_ctrl.sv
verilog/ex_top.sv
verification/ex_sva.sv
verification/ex_tb.sv

/* verification/ex_sva.sv */
`timescale 1ns/1ps

module ex_sva (
    input logic               clk,
    input logic               rst_n,
    input logic               block,
    input logic               valid,
    input ex_pkg::ex_issue_t  issue,
    input ex_pkg::ex_issue_t  cur,
    input ex_pkg::ex_result_t ex_out
);

    // Valid drops the cycle after a reset edge even while blocked
    valid_after_reset: assert property (@(posedge clk) !rst_n |=> !valid)
        else $error("valid still high one cycle after reset");

    stall_hold: assert property (
        @(posedge clk) (rst_n && block) |=> ($stable(cur) && $stable(valid))
    ) else $error("stage register or valid changed while blocked");

    // An accepted CSR bundle redirects fetch in the next cycle
    csr_jump: assert property (@(posedge clk) (!block && issue.csr) |=> ex_out.is_jmp)
        else $error("CSR bundle without the jump flag");

endmodule

/* verification/ex_tb.sv */
`timescale 1ns/1ps

module ex_tb;
    import ex_pkg::*;

    localparam int NUM_TESTS    = 2000;
    localparam int RESET_CYCLES = 16;
    localparam int MID_RESET_AT = NUM_TESTS / 2;
    localparam int MAX_CYCLES   = NUM_TESTS * 3 / 2;   // Bundles plus about one stall in three

    logic       clk = 1'b0;
    logic       rst_n;
    logic       valid_in;
    logic       block;
    logic       valid;
    ex_issue_t  issue;
    ex_result_t ex_out;

    logic [31:0] lcg_state;
    ex_issue_t   exp_cur;      // Model copy of the stage register
    logic        exp_valid;
    ex_result_t  prev_out;
    logic        prev_valid;
    logic        held;         // Last edge stalled outside reset
    int          err_count = 0;
    int          cycles = 0;

    ex_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .valid_in (valid_in),
        .block    (block),
        .ex_out   (ex_out),
        .valid    (valid)
    );

    bind ex_ctrl ex_sva u_sva (
        .clk    (clk),
        .rst_n  (rst_n),
        .block  (block),
        .valid  (valid),
        .issue  (issue),
        .cur    (cur),
        .ex_out (ex_out)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "simulation timed out");
        end
    end

    // Tempered LCG so the low bits are usable too
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    function automatic xlen_t rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    function automatic ex_issue_t random_issue();
        ex_issue_t   t;
        logic [31:0] r;
        t.src1     = rand64();
        t.src2     = rand64();
        t.csr_data = rand64();
        t.pc       = rand64();
        t.pc[1:0]  = 2'b00;
        t.imm      = next_rand();
        r          = next_rand();
        if (r[1:0] == 2'd0) begin
            t.src2 = t.src1;   // Equal operands so beq/bne go both ways
        end
        t.csr_addr = r[13:2];
        t.rd       = r[18:14];
        t.rs1      = r[23:19];
        t.a_is_pc  = r[24];
        t.mem_op   = r[27:25];
        t.mem_rd   = r[28];
        t.mem_wr   = r[29];
        t.reg_wr   = r[30];
        t.done     = r[31];
        r          = next_rand();
        t.csr      = (r[2:0] == 3'd0);
        t.error    = (r[5:3] == 3'd0);
        t.alu_op   = alu_op_e'(5'(next_rand() % 32'd16));
        t.b_sel    = b_sel_e'(2'(next_rand() % 32'd4));
        t.branch   = branch_e'(3'(next_rand() % 32'd7));
        return t;
    endfunction

    function automatic xlen_t alu_model(alu_op_e op, xlen_t a, xlen_t b);
        logic [31:0] w;
        xlen_t       r;
        w = 32'd0;
        r = 64'd0;
        case (op)
            alu_add:    r = a + b;
            alu_sub:    r = a - b;
            alu_sll:    r = a << b[5:0];
            alu_slt:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            alu_sltu:   r = (a < b) ? 64'd1 : 64'd0;
            alu_xor:    r = a ^ b;
            alu_srl:    r = a >> b[5:0];
            alu_sra:    r = $signed(a) >>> b[5:0];
            alu_or:     r = a | b;
            alu_and:    r = a & b;
            alu_copy_b: r = b;
            alu_addw:   w = a[31:0] + b[31:0];
            alu_subw:   w = a[31:0] - b[31:0];
            alu_sllw:   w = a[31:0] << b[4:0];
            alu_srlw:   w = a[31:0] >> b[4:0];
            alu_sraw:   w = $signed(a[31:0]) >>> b[4:0];
            default:    r = 64'd0;
        endcase
        if (op inside {alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw}) begin
            r = {{32{w[31]}}, w};
        end
        return r;
    endfunction

    function automatic ex_result_t expected_out(ex_issue_t c);
        ex_result_t e;
        xlen_t      imm64;
        xlen_t      a;
        xlen_t      b;
        xlen_t      res;
        xlen_t      tgt;
        logic       tk;
        imm64 = {{32{c.imm[31]}}, c.imm};
        a = c.a_is_pc ? c.pc : c.src1;
        case (c.b_sel)
            b_rs2:   b = c.src2;
            b_four:  b = 64'd4;
            b_imm:   b = imm64;
            default: b = c.csr_data;
        endcase
        res = alu_model(c.alu_op, a, b);
        tgt = c.pc + imm64;
        case (c.branch)
            br_jal:  tk = 1'b1;
            br_jalr: begin
                tk  = 1'b1;
                tgt = (c.src1 + imm64) & ~64'd1;
            end
            br_beq:  tk = (res == 64'd0);
            br_bne:  tk = (res != 64'd0);
            br_blt:  tk = res[0];
            br_bge:  tk = !res[0];
            default: tk = 1'b0;
        endcase
        e.result   = res;
        e.nxtpc    = tk ? tgt : c.pc + 64'd4;
        e.pc       = c.pc;
        e.src1     = c.src1;
        e.src2     = c.src2;
        e.csr_data = c.csr_data;
        e.csr_addr = c.csr_addr;
        e.rd       = c.rd;
        e.rs1      = c.rs1;
        e.mem_op   = c.mem_op;
        e.is_jmp   = tk | c.csr;
        e.mem_rd   = c.mem_rd;
        e.mem_wr   = c.mem_wr;
        e.reg_wr   = c.reg_wr;
        e.done     = c.done;
        e.error    = c.error;
        return e;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %s expected=%h actual=%h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic model_edge();
        if (!block) begin
            exp_cur = issue;
        end
        if (!rst_n) begin
            exp_valid = 1'b0;
        end else if (!block) begin
            exp_valid = valid_in;
        end
        held = rst_n && block;
    endtask

    task automatic check_outputs();
        ex_result_t e;
        e = expected_out(exp_cur);
        check("valid", 64'(exp_valid), 64'(valid));
        if (held) begin
            check("held valid", 64'(prev_valid), 64'(valid));
            check("held result", prev_out.result, ex_out.result);
            check("held nxtpc", prev_out.nxtpc, ex_out.nxtpc);
        end
        if (valid) begin
            check("result", e.result, ex_out.result);
            check("nxtpc", e.nxtpc, ex_out.nxtpc);
            check("is_jmp", 64'(e.is_jmp), 64'(ex_out.is_jmp));
            check("pc", e.pc, ex_out.pc);
            check("src1", e.src1, ex_out.src1);
            check("src2", e.src2, ex_out.src2);
            check("csr_data", e.csr_data, ex_out.csr_data);
            check("csr_addr", 64'(e.csr_addr), 64'(ex_out.csr_addr));
            check("rd", 64'(e.rd), 64'(ex_out.rd));
            check("rs1", 64'(e.rs1), 64'(ex_out.rs1));
            check("mem_op", 64'(e.mem_op), 64'(ex_out.mem_op));
            check("mem_rd", 64'(e.mem_rd), 64'(ex_out.mem_rd));
            check("mem_wr", 64'(e.mem_wr), 64'(ex_out.mem_wr));
            check("reg_wr", 64'(e.reg_wr), 64'(ex_out.reg_wr));
            check("done", 64'(e.done), 64'(ex_out.done));
            check("error", 64'(e.error), 64'(ex_out.error));
        end
        prev_out   = ex_out;
        prev_valid = valid;
    endtask

    // Rising edge updates the model, falling edge checks and hands back for driving
    task automatic clock_cycle();
        @(posedge clk);
        model_edge();
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        ex_issue_t   bundle;
        logic [31:0] r;
        lcg_state  = 32'd17;
        held       = 1'b0;
        exp_valid  = 1'b0;
        prev_valid = 1'b0;
        exp_cur    = '0;
        prev_out   = '0;
        rst_n      = 1'b0;
        block      = 1'b0;
        valid_in   = 1'b0;
        issue      = random_issue();
        repeat (RESET_CYCLES) clock_cycle();
        rst_n = 1'b1;
        for (int n = 0; n < NUM_TESTS; n++) begin
            bundle   = random_issue();
            r        = next_rand();
            issue    = bundle;
            valid_in = (r[3:0] != 4'd0);
            if (n == MID_RESET_AT) begin
                rst_n = 1'b0;   // Reset while stalled
                block = 1'b1;
                clock_cycle();
                rst_n = 1'b1;
            end
            r = next_rand();
            while (r[1:0] == 2'd0) begin
                block = 1'b1;   // Upstream holds the bundle
                clock_cycle();
                r = next_rand();
            end
            block = 1'b0;
            clock_cycle();
        end
        valid_in = 1'b0;
        clock_cycle();
        if (err_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "errors found");
        end
    end

endmodule

/* verilog/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::xlen_t   a,
    input  ex_pkg::xlen_t   b,
    input  ex_pkg::alu_op_e op,
    output ex_pkg::xlen_t   result,
    output logic            zero
);
    import ex_pkg::*;

    logic [5:0]  shamt;
    logic [4:0]  shamt_w;
    logic [31:0] word;
    xlen_t       word_sext;
    logic        lt_s;
    logic        lt_u;

    assign shamt   = b[5:0];
    assign shamt_w = b[4:0];   // Word shifts ignore b[5]

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    // 32-bit datapath for the W forms
    always_comb begin
        case (op)
            alu_subw: word = a[31:0] - b[31:0];
            alu_sllw: word = a[31:0] << shamt_w;
            alu_srlw: word = a[31:0] >> shamt_w;
            alu_sraw: word = $signed(a[31:0]) >>> shamt_w;
            default:  word = a[31:0] + b[31:0];
        endcase
    end

    assign word_sext = {{32{word[31]}}, word};

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(XLEN-1){1'b0}}, lt_s};
            alu_sltu:   result = {{(XLEN-1){1'b0}}, lt_u};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_copy_b: result = b;      // lui
            alu_addw,
            alu_subw,
            alu_sllw,
            alu_srlw,
            alu_sraw:   result = word_sext;
            default:    result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* verilog/ex_branch.sv */
`timescale 1ns/1ps

module ex_branch (
    input  ex_pkg::xlen_t   pc,
    input  ex_pkg::xlen_t   rs1_val,
    input  ex_pkg::imm_t    imm,
    input  ex_pkg::branch_e kind,
    input  logic            zero,
    input  logic            lsb,
    output ex_pkg::xlen_t   nxtpc,
    output logic            taken
);
    import ex_pkg::*;

    xlen_t imm_sext;
    xlen_t pc_target;
    xlen_t jalr_sum;
    xlen_t seq_pc;

    assign imm_sext  = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    assign pc_target = pc + imm_sext;
    assign jalr_sum  = rs1_val + imm_sext;
    assign seq_pc    = pc + INSN_BYTES;

    // beq/bne look at the subtract result, blt/bge at the slt(u) bit
    always_comb begin
        case (kind)
            br_jal:  taken = 1'b1;
            br_jalr: taken = 1'b1;
            br_beq:  taken = zero;
            br_bne:  taken = ~zero;
            br_blt:  taken = lsb;
            br_bge:  taken = ~lsb;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (!taken) begin
            nxtpc = seq_pc;
        end else if (kind == br_jalr) begin
            nxtpc = {jalr_sum[XLEN-1:1], 1'b0};   // Target LSB cleared
        end else begin
            nxtpc = pc_target;
        end
    end

endmodule

/* verilog/ex_ctrl.sv */
`timescale 1ns/1ps

module ex_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  ex_pkg::ex_issue_t  issue,
    input  logic               valid_in,
    input  logic               block,
    input  ex_pkg::xlen_t      result,
    input  ex_pkg::xlen_t      nxtpc,
    input  logic               taken,
    output ex_pkg::xlen_t      op_a,
    output ex_pkg::xlen_t      op_b,
    output ex_pkg::alu_op_e    alu_op,
    output ex_pkg::ex_issue_t  cur,
    output ex_pkg::ex_result_t ex_out,
    output logic               valid
);
    import ex_pkg::*;

    xlen_t imm_sext;

    // Stage register, captured whether or not the bundle is valid
    always_ff @(posedge clk) begin
        if (!block) begin
            cur <= issue;
        end
    end

    // Reset wins over block so a stalled stage still empties
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (!block) begin
            valid <= valid_in;
        end
    end

    assign imm_sext = {{(XLEN-IMM_W){cur.imm[IMM_W-1]}}, cur.imm};

    assign op_a   = cur.a_is_pc ? cur.pc : cur.src1;  // auipc and jal use the PC
    assign alu_op = cur.alu_op;

    always_comb begin
        case (cur.b_sel)
            b_rs2:   op_b = cur.src2;
            b_four:  op_b = INSN_BYTES;    // Link address pc + 4
            b_imm:   op_b = imm_sext;
            b_csr:   op_b = cur.csr_data;
            default: op_b = cur.src2;
        endcase
    end

    // Result bundle for the memory stage
    always_comb begin
        ex_out.result   = result;
        ex_out.nxtpc    = nxtpc;
        ex_out.pc       = cur.pc;
        ex_out.src1     = cur.src1;
        ex_out.src2     = cur.src2;
        ex_out.csr_data = cur.csr_data;
        ex_out.csr_addr = cur.csr_addr;
        ex_out.rd       = cur.rd;
        ex_out.rs1      = cur.rs1;
        ex_out.mem_op   = cur.mem_op;
        // A CSR access always redirects fetch
        ex_out.is_jmp   = taken | cur.csr;
        ex_out.mem_rd   = cur.mem_rd;
        ex_out.mem_wr   = cur.mem_wr;
        ex_out.reg_wr   = cur.reg_wr;
        ex_out.done     = cur.done;
        ex_out.error    = cur.error;
    end

endmodule

/* verilog/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN  = 64;
    localparam int IMM_W = 32;

    typedef logic [XLEN-1:0]  xlen_t;     // Data word or PC
    typedef logic [IMM_W-1:0] imm_t;      // Raw immediate from decode
    typedef logic [4:0]       reg_idx_t;
    typedef logic [11:0]      csr_addr_t;
    typedef logic [2:0]       mem_op_t;   // Load/store width and sign, used downstream

    // Step between sequential instructions, also the link offset for jal/jalr
    localparam xlen_t INSN_BYTES = 64'd4;

    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_sll    = 5'd2,
        alu_slt    = 5'd3,
        alu_sltu   = 5'd4,
        alu_xor    = 5'd5,
        alu_srl    = 5'd6,
        alu_sra    = 5'd7,
        alu_or     = 5'd8,
        alu_and    = 5'd9,
        alu_copy_b = 5'd10,
        alu_addw   = 5'd11,
        alu_subw   = 5'd12,
        alu_sllw   = 5'd13,
        alu_srlw   = 5'd14,
        alu_sraw   = 5'd15
    } alu_op_e;

    typedef enum logic [1:0] {
        b_rs2  = 2'd0,
        b_four = 2'd1,
        b_imm  = 2'd2,
        b_csr  = 2'd3
    } b_sel_e;

    // Unsigned compares reuse blt/bge with alu_sltu
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_jal  = 3'd1,
        br_jalr = 3'd2,
        br_beq  = 3'd3,
        br_bne  = 3'd4,
        br_blt  = 3'd5,
        br_bge  = 3'd6
    } branch_e;

    typedef struct packed {
        xlen_t     src1;
        xlen_t     src2;
        xlen_t     csr_data;
        xlen_t     pc;
        imm_t      imm;
        csr_addr_t csr_addr;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        logic      a_is_pc;
        b_sel_e    b_sel;
        alu_op_e   alu_op;
        branch_e   branch;
        mem_op_t   mem_op;
        logic      mem_rd;
        logic      mem_wr;
        logic      reg_wr;
        logic      csr;
        logic      done;
        logic      error;
    } ex_issue_t;

    typedef struct packed {
        xlen_t     result;
        xlen_t     nxtpc;
        xlen_t     pc;
        xlen_t     src1;
        xlen_t     src2;
        xlen_t     csr_data;
        csr_addr_t csr_addr;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        mem_op_t   mem_op;
        logic      is_jmp;
        logic      mem_rd;
        logic      mem_wr;
        logic      reg_wr;
        logic      done;
        logic      error;
    } ex_result_t;

endpackage

/* verilog/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
    input  logic               clk,
    input  logic               rst_n,
    input  ex_pkg::ex_issue_t  issue,
    input  logic               valid_in,
    input  logic               block,
    output ex_pkg::ex_result_t ex_out,
    output logic               valid
);
    import ex_pkg::*;

    xlen_t     op_a;
    xlen_t     op_b;
    alu_op_e   alu_op;
    ex_issue_t cur;
    xlen_t     result;
    logic      zero;
    xlen_t     nxtpc;
    logic      taken;

    ex_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .valid_in (valid_in),
        .block    (block),
        .result   (result),
        .nxtpc    (nxtpc),
        .taken    (taken),
        .op_a     (op_a),
        .op_b     (op_b),
        .alu_op   (alu_op),
        .cur      (cur),
        .ex_out   (ex_out),
        .valid    (valid)
    );

    ex_alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op),
        .result (result),
        .zero   (zero)
    );

    ex_branch u_branch (
        .pc      (cur.pc),
        .rs1_val (cur.src1),
        .imm     (cur.imm),
        .kind    (cur.branch),
        .zero    (zero),
        .lsb     (result[0]),
        .nxtpc   (nxtpc),
        .taken   (taken)
    );

endmodule
